// ==== include/wisc_params.svh ====
// Global sizing macros for the core, included by every RTL file that needs a width or reset value
`ifndef WISC_PARAMS_SVH
`define WISC_PARAMS_SVH

// Datapath and instruction width in bits
`define WISC_DATA_W 16

// Architectural registers R0..R7
`define WISC_NUM_REGS 8

// First fetch address after reset
`define WISC_RESET_PC 'h0

`endif

// ==== hdl/wiscPkg.sv ====
// Shared opcode, control-field and bus types for the core; modules import this package where they use it
`include "wisc_params.svh"

package wiscPkg;

    // Opcode field instr[15:11], encodings follow the decoder's groups
    typedef enum logic [4:0] {
        HALT      = 5'b00000, NOP       = 5'b00001, SIIC      = 5'b00010, RTI  = 5'b00011,
        J         = 5'b00100, JR        = 5'b00101, JAL       = 5'b00110, JALR = 5'b00111,
        ADDI      = 5'b01000, SUBI      = 5'b01001, XORI      = 5'b01010, ANDNI = 5'b01011,
        BEQZ      = 5'b01100, BNEZ      = 5'b01101, BLTZ      = 5'b01110, BGEZ = 5'b01111,
        ST        = 5'b10000, LD        = 5'b10001, SLBI      = 5'b10010, STU  = 5'b10011,
        ROLI      = 5'b10100, SLLI      = 5'b10101, RORI      = 5'b10110, SRLI = 5'b10111,
        LBI       = 5'b11000, BTR       = 5'b11001, ALU_SHIFT = 5'b11010, ALU_ARITH = 5'b11011,
        SEQ       = 5'b11100, SLT       = 5'b11101, SLE       = 5'b11110, SCO  = 5'b11111
    } opcodeT;

    // ALU operations; add and rol are refined by funct bits in the R groups
    typedef enum logic [3:0] {
        aluAdd, aluSub, aluXor, aluAndn,
        aluRol, aluSll, aluRor, aluSrl,
        aluSeq, aluSlt, aluSle, aluSco,
        aluBtr, aluPassB, aluSlbi
    } aluOpT;

    typedef enum logic [2:0] {
        immZero5, immSign5, immZero8, immSign8, immSign11
    } immSelT;

    // Same order as the decoder's DestRegSel: Rs, Rd-R, R7, Rd-I
    typedef enum logic [1:0] {
        destRs, destRdR, destR7, destRdI
    } destSelT;

    typedef struct packed {
        logic     regWrite;  // Register file write
        destSelT  destSel;
        immSelT   immSel;
        aluOpT    aluOp;
        logic     aluUseImm; // Immediate replaces Rt as operand B
        logic     memEnable;
        logic     memWr;
        logic     memToReg;  // Load data to register
        logic     link;      // PC+2 to register
        logic     branch;    // PC-relative target
        logic     jump;      // Unconditional, J and JAL
        logic     regJump;   // Target is Rs + imm
        logic [1:0] brCond;  // 00 eqz, 01 nez, 10 ltz, 11 gez
        logic     halt;
    } ctrlT;

    typedef struct packed {
        logic                    enable;
        logic                    write;
        logic [`WISC_DATA_W-1:0] addr;
        logic [`WISC_DATA_W-1:0] wrData;
    } memReqT;

    typedef struct packed {
        logic                              valid;
        logic [$clog2(`WISC_NUM_REGS)-1:0] addr;
        logic [`WISC_DATA_W-1:0]           data;
    } wbT;

endpackage

// ==== hdl/control.sv ====
// Opcode decoder producing the full control word for one instruction; instantiated by decodeStage
`timescale 1ns/1ns

module control (
    input  wiscPkg::opcodeT opcode,
    output wiscPkg::ctrlT   ctrl
);
    import wiscPkg::*;

    always_comb begin
        // Safe defaults, a plain NOP
        ctrl.regWrite  = 1'b0;
        ctrl.destSel   = destRdI;
        ctrl.immSel    = immSign5;
        ctrl.aluOp     = aluAdd;
        ctrl.aluUseImm = 1'b1;
        ctrl.memEnable = 1'b0;
        ctrl.memWr     = 1'b0;
        ctrl.memToReg  = 1'b0;
        ctrl.link      = 1'b0;
        ctrl.branch    = 1'b0;
        ctrl.jump      = 1'b0;
        ctrl.regJump   = 1'b0;
        ctrl.brCond    = opcode[1:0]; // Only looked at for branches
        ctrl.halt      = 1'b0;

        case (opcode)
            HALT: ctrl.halt = 1'b1;
            NOP, SIIC, RTI: ;            // No exception logic, all three retire as NOP

            // I-format 1, arithmetic forms sign extend, logical forms zero extend
            ADDI, SUBI, ROLI, SLLI: begin
                ctrl.regWrite = 1'b1;
                ctrl.immSel   = immSign5;
                case (opcode)
                    ADDI:    ctrl.aluOp = aluAdd;
                    SUBI:    ctrl.aluOp = aluSub;
                    ROLI:    ctrl.aluOp = aluRol;
                    default: ctrl.aluOp = aluSll;
                endcase
            end
            XORI, ANDNI, RORI, SRLI: begin
                ctrl.regWrite = 1'b1;
                ctrl.immSel   = immZero5;
                case (opcode)
                    XORI:    ctrl.aluOp = aluXor;
                    ANDNI:   ctrl.aluOp = aluAndn;
                    RORI:    ctrl.aluOp = aluRor;
                    default: ctrl.aluOp = aluSrl;
                endcase
            end

            // Memory ops, address is Rs + sext(imm5)
            ST: begin
                ctrl.memEnable = 1'b1;
                ctrl.memWr     = 1'b1;
            end
            LD: begin
                ctrl.memEnable = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.regWrite  = 1'b1;
            end
            STU: begin
                ctrl.memEnable = 1'b1;
                ctrl.memWr     = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.destSel   = destRs;   // Rs gets the effective address
            end

            LBI: begin
                ctrl.regWrite = 1'b1;
                ctrl.destSel  = destRs;
                ctrl.immSel   = immSign8;
                ctrl.aluOp    = aluPassB;
            end
            SLBI: begin
                ctrl.regWrite = 1'b1;
                ctrl.destSel  = destRs;
                ctrl.immSel   = immZero8;
                ctrl.aluOp    = aluSlbi;
            end

            // R-format, Rd in bits 4:2
            BTR, ALU_ARITH, ALU_SHIFT, SEQ, SLT, SLE, SCO: begin
                ctrl.regWrite  = 1'b1;
                ctrl.destSel   = destRdR;
                ctrl.aluUseImm = 1'b0;
                case (opcode)
                    BTR:       ctrl.aluOp = aluBtr;
                    ALU_ARITH: ctrl.aluOp = aluAdd; // Funct picks add/sub/xor/andn
                    ALU_SHIFT: ctrl.aluOp = aluRol; // Funct picks rol/sll/ror/srl
                    SEQ:       ctrl.aluOp = aluSeq;
                    SLT:       ctrl.aluOp = aluSlt;
                    SLE:       ctrl.aluOp = aluSle;
                    default:   ctrl.aluOp = aluSco;
                endcase
            end

            BEQZ, BNEZ, BLTZ, BGEZ: begin
                ctrl.branch = 1'b1;           // Taken only if Rs meets brCond
                ctrl.immSel = immSign8;
            end

            J, JAL: begin
                ctrl.branch = 1'b1;
                ctrl.jump   = 1'b1;
                ctrl.immSel = immSign11;
                if (opcode == JAL) begin
                    ctrl.link     = 1'b1;
                    ctrl.regWrite = 1'b1;
                    ctrl.destSel  = destR7;
                end
            end
            JR, JALR: begin
                ctrl.regJump = 1'b1;          // ALU forms Rs + sext(imm8)
                ctrl.immSel  = immSign8;
                if (opcode == JALR) begin
                    ctrl.link     = 1'b1;
                    ctrl.regWrite = 1'b1;
                    ctrl.destSel  = destR7;
                end
            end

            default: ;
        endcase
    end

endmodule

// ==== hdl/regFile.sv ====
// Eight-entry register file, two combinational read ports and one clocked write port; used by decodeStage
`timescale 1ns/1ns
`include "wisc_params.svh"

module regFile #(
    parameter int AW = $clog2(`WISC_NUM_REGS)
) (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [AW-1:0]           rsAddr,
    input  logic [AW-1:0]           rtAddr,
    input  logic                    wrEn,
    input  logic [AW-1:0]           wrAddr,
    input  logic [`WISC_DATA_W-1:0] wrData,
    output logic [`WISC_DATA_W-1:0] rsVal,
    output logic [`WISC_DATA_W-1:0] rtVal
);

    logic [`WISC_DATA_W-1:0] regs [`WISC_NUM_REGS]; // R0 is a normal register

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `WISC_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // No write bypass, a read sees the value from before this edge
    assign rsVal = regs[rsAddr];
    assign rtVal = regs[rtAddr];

endmodule

// ==== hdl/decodeStage.sv ====
// Decode stage with the opcode decoder, register file, immediate extension and write-back select
`timescale 1ns/1ns
`include "wisc_params.svh"

module decodeStage (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [`WISC_DATA_W-1:0] instr,
    input  logic [`WISC_DATA_W-1:0] pcPlus2,
    input  logic [`WISC_DATA_W-1:0] aluOut,
    input  logic [`WISC_DATA_W-1:0] memRdData,
    input  logic                    halted,
    output wiscPkg::ctrlT           ctrl,
    output logic [`WISC_DATA_W-1:0] rsVal,
    output logic [`WISC_DATA_W-1:0] rtVal,
    output logic [`WISC_DATA_W-1:0] imm,
    output wiscPkg::wbT             wb
);
    import wiscPkg::*;

    localparam int W = `WISC_DATA_W;

    control control_i (
        .opcode (opcodeT'(instr[15:11])),
        .ctrl   (ctrl)
    );

    // Bits 7:5 are Rt in R-format and Rd in I-format, so the store data port covers both
    regFile regFile_i (
        .clk    (clk),
        .rstN   (rstN),
        .rsAddr (instr[10:8]),
        .rtAddr (instr[7:5]),
        .wrEn   (wb.valid),
        .wrAddr (wb.addr),
        .wrData (wb.data),
        .rsVal  (rsVal),
        .rtVal  (rtVal)
    );

    always_comb begin
        case (ctrl.immSel)
            immZero5:  imm = {{(W-5){1'b0}}, instr[4:0]};
            immSign5:  imm = {{(W-5){instr[4]}}, instr[4:0]};
            immZero8:  imm = {{(W-8){1'b0}}, instr[7:0]};
            immSign8:  imm = {{(W-8){instr[7]}}, instr[7:0]};
            default:   imm = {{(W-11){instr[10]}}, instr[10:0]}; // J displacement
        endcase
    end

    always_comb begin
        wb.valid = ctrl.regWrite & ~halted;     // No retirement once stopped
        case (ctrl.destSel)
            destRs:  wb.addr = instr[10:8];
            destRdR: wb.addr = instr[4:2];
            destR7:  wb.addr = 3'(`WISC_NUM_REGS - 1);
            default: wb.addr = instr[7:5];
        endcase
        if (ctrl.memToReg) begin
            wb.data = memRdData;
        end else if (ctrl.link) begin
            wb.data = pcPlus2;                  // Return address for JAL and JALR
        end else begin
            wb.data = aluOut;
        end
    end

endmodule

// ==== hdl/alu.sv ====
// Combinational ALU for arithmetic, logic, shifts, rotates, set-condition, bit reverse and byte loads
`timescale 1ns/1ns
`include "wisc_params.svh"

module alu (
    input  wiscPkg::ctrlT           ctrl,
    input  logic [1:0]              instrFunct,
    input  logic [`WISC_DATA_W-1:0] rsVal,
    input  logic [`WISC_DATA_W-1:0] rtVal,
    input  logic [`WISC_DATA_W-1:0] imm,
    output logic [`WISC_DATA_W-1:0] aluOut
);
    import wiscPkg::*;

    localparam int W  = `WISC_DATA_W;
    localparam int SW = $clog2(`WISC_DATA_W);

    aluOpT          op;       // Operation after funct refinement
    logic [W-1:0]   opB;
    logic [W:0]     sum;      // Extra bit is SCO carry
    logic [SW-1:0]  shamt;
    logic [2*W-1:0] rotL;
    logic [2*W-1:0] rotR;
    logic [W-1:0]   rev;

    assign opB   = ctrl.aluUseImm ? imm : rtVal;
    assign sum   = {1'b0, rsVal} + {1'b0, opB};
    assign shamt = opB[SW-1:0];
    assign rotL  = {rsVal, rsVal} << shamt;   // Upper half is the left rotate
    assign rotR  = {rsVal, rsVal} >> shamt;   // Lower half is the right rotate

    always_comb begin
        for (int i = 0; i < W; i++) begin
            rev[i] = rsVal[W-1-i];
        end
    end

    // R groups share one decoder value, funct selects the exact op
    always_comb begin
        op = ctrl.aluOp;
        if (!ctrl.aluUseImm && ctrl.aluOp == aluAdd) begin
            case (instrFunct)
                2'b00:   op = aluAdd;
                2'b01:   op = aluSub;
                2'b10:   op = aluXor;
                default: op = aluAndn;
            endcase
        end else if (!ctrl.aluUseImm && ctrl.aluOp == aluRol) begin
            case (instrFunct)
                2'b00:   op = aluRol;
                2'b01:   op = aluSll;
                2'b10:   op = aluRor;
                default: op = aluSrl;
            endcase
        end
    end

    always_comb begin
        aluOut = '0;
        case (op)
            aluAdd:   aluOut = sum[W-1:0];            // Also LD/ST/STU address and JR target
            aluSub:   aluOut = opB - rsVal;           // B minus Rs
            aluXor:   aluOut = rsVal ^ opB;
            aluAndn:  aluOut = rsVal & ~opB;
            aluRol:   aluOut = rotL[2*W-1:W];
            aluSll:   aluOut = rsVal << shamt;
            aluRor:   aluOut = rotR[W-1:0];
            aluSrl:   aluOut = rsVal >> shamt;
            aluSeq:   aluOut[0] = (rsVal == opB);
            aluSlt:   aluOut[0] = ($signed(rsVal) < $signed(opB));
            aluSle:   aluOut[0] = ($signed(rsVal) <= $signed(opB));
            aluSco:   aluOut[0] = sum[W];
            aluBtr:   aluOut = rev;
            aluPassB: aluOut = opB;                   // LBI
            aluSlbi:  aluOut = (rsVal << 8) | opB;    // opB is zero extended imm8
            default:  aluOut = sum[W-1:0];
        endcase
    end

endmodule

// ==== hdl/fetchUnit.sv ====
// Program counter with branch resolution, next-PC select and the halt latch; instantiated by wiscCore
`timescale 1ns/1ns
`include "wisc_params.svh"

module fetchUnit (
    input  logic                    clk,
    input  logic                    rstN,
    input  wiscPkg::ctrlT           ctrl,
    input  logic [`WISC_DATA_W-1:0] rsVal,
    input  logic [`WISC_DATA_W-1:0] imm,
    input  logic [`WISC_DATA_W-1:0] aluOut,
    output logic [`WISC_DATA_W-1:0] pc,
    output logic [`WISC_DATA_W-1:0] pcPlus2,
    output logic                    halted
);

    logic                    condMet;
    logic                    taken;
    logic [`WISC_DATA_W-1:0] nextPc;

    assign pcPlus2 = pc + `WISC_DATA_W'(2);

    always_comb begin
        case (ctrl.brCond)
            2'b00:   condMet = (rsVal == '0);            // BEQZ
            2'b01:   condMet = (rsVal != '0);            // BNEZ
            2'b10:   condMet = rsVal[`WISC_DATA_W-1];    // BLTZ
            default: condMet = ~rsVal[`WISC_DATA_W-1];   // BGEZ
        endcase
    end

    assign taken = ctrl.branch & (ctrl.jump | condMet);

    always_comb begin
        if (halted || ctrl.halt) begin
            nextPc = pc;                   // Park on the HALT word
        end else if (ctrl.regJump) begin
            nextPc = aluOut;
        end else if (taken) begin
            nextPc = pcPlus2 + imm;
        end else begin
            nextPc = pcPlus2;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc     <= `WISC_RESET_PC;
            halted <= 1'b0;
        end else begin
            pc     <= nextPc;
            halted <= halted | ctrl.halt;  // Sticky until reset
        end
    end

endmodule

// ==== hdl/wiscCore.sv ====
// Single-cycle core top level; instruction and data memories are external and answer combinationally
`timescale 1ns/1ns
`include "wisc_params.svh"

module wiscCore (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [`WISC_DATA_W-1:0] instr,
    input  logic [`WISC_DATA_W-1:0] memRdData,
    output logic [`WISC_DATA_W-1:0] pc,
    output wiscPkg::memReqT         memReq,
    output wiscPkg::wbT             wb,
    output logic                    halted
);
    import wiscPkg::*;

    ctrlT                    ctrl;
    logic [`WISC_DATA_W-1:0] pcPlus2;
    logic [`WISC_DATA_W-1:0] rsVal;
    logic [`WISC_DATA_W-1:0] rtVal;
    logic [`WISC_DATA_W-1:0] imm;
    logic [`WISC_DATA_W-1:0] aluOut;

    fetchUnit fetchUnit_i (
        .clk     (clk),
        .rstN    (rstN),
        .ctrl    (ctrl),
        .rsVal   (rsVal),
        .imm     (imm),
        .aluOut  (aluOut),
        .pc      (pc),
        .pcPlus2 (pcPlus2),
        .halted  (halted)
    );

    decodeStage decodeStage_i (
        .clk       (clk),
        .rstN      (rstN),
        .instr     (instr),
        .pcPlus2   (pcPlus2),
        .aluOut    (aluOut),
        .memRdData (memRdData),
        .halted    (halted),
        .ctrl      (ctrl),
        .rsVal     (rsVal),
        .rtVal     (rtVal),
        .imm       (imm),
        .wb        (wb)
    );

    alu alu_i (
        .ctrl       (ctrl),
        .instrFunct (instr[1:0]),
        .rsVal      (rsVal),
        .rtVal      (rtVal),
        .imm        (imm),
        .aluOut     (aluOut)
    );

    // Data port, store data is the register at bits 7:5
    assign memReq.enable = ctrl.memEnable & ~halted;
    assign memReq.write  = ctrl.memWr;
    assign memReq.addr   = aluOut;
    assign memReq.wrData = rtVal;

endmodule

// ==== test/wiscCoreTb.sv ====
// Directed-test testbench for wiscCore with instruction and data memory models and a reference model
`timescale 1ns/1ns

module wiscCoreTb;
    import wiscPkg::*;

    localparam int MaxCycles = 2000;  // All six programs with their resets take about 330 cycles

    logic        clk;
    logic        rstN;
    logic [15:0] instr;
    logic [15:0] memRdData;
    logic [15:0] pc;
    memReqT      memReq;
    wbT          wb;
    logic        halted;

    logic [15:0] imem [1024];          // Program words indexed by pc[10:1]
    logic [15:0] dmem [32768];         // Data memory seen by the DUT
    logic        memFilled = 1'b0;
    logic [15:0] mReg [8];             // Reference registers
    logic [15:0] mMem [32768];         // Reference data memory
    logic [15:0] mPc;
    logic        mHalted;
    logic [9:0]  wp;                   // Next free program slot
    int          seed;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    string       testName;

    // Expected response for the instruction at mPc
    logic        expValid;
    logic [2:0]  expAddr;
    logic [15:0] expData;
    logic        expMemEn;
    logic        expMemWr;
    logic [15:0] expMemAddr;
    logic [15:0] expMemData;
    logic        expHalt;
    logic [15:0] nextPc;

    wiscCore wiscCore_i (
        .clk       (clk),
        .rstN      (rstN),
        .instr     (instr),
        .memRdData (memRdData),
        .pc        (pc),
        .memReq    (memReq),
        .wb        (wb),
        .halted    (halted)
    );

    assign instr     = imem[pc[10:1]];          // Both memories answer in the same cycle
    assign memRdData = dmem[memReq.addr[15:1]];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!memFilled) begin
            for (int i = 0; i < 32768; i++) begin
                dmem[15'(i)] <= {i[14:0], 1'b1} ^ 16'h3c5a;  // Same pattern as mMem
            end
            memFilled <= 1'b1;
        end else if (memReq.enable && memReq.write) begin
            dmem[memReq.addr[15:1]] <= memReq.wrData;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MaxCycles) begin
            $display("Timeout: run did not finish within %0d cycles", MaxCycles);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [15:0] rInstr(opcodeT op, logic [2:0] rs, logic [2:0] rt,
                                           logic [2:0] rd, logic [1:0] fn);
        return {op, rs, rt, rd, fn};
    endfunction

    function automatic logic [15:0] immInstr(opcodeT op, logic [2:0] rs, logic [2:0] rd,
                                             logic [4:0] imm);
        return {op, rs, rd, imm};
    endfunction

    function automatic logic [15:0] byteInstr(opcodeT op, logic [2:0] rs, logic [7:0] imm);
        return {op, rs, imm};
    endfunction

    function automatic logic [15:0] jumpInstr(opcodeT op, logic [10:0] disp);
        return {op, disp};
    endfunction

    function automatic logic [15:0] rotl(logic [15:0] x, logic [3:0] n);
        return (x << n) | (x >> (5'd16 - {1'b0, n}));
    endfunction

    function automatic logic [15:0] rotr(logic [15:0] x, logic [3:0] n);
        return (x >> n) | (x << (5'd16 - {1'b0, n}));
    endfunction

    task automatic startProgram(input string name);
        testName = name;
        for (int i = 0; i < 1024; i++) begin
            imem[10'(i)] = 16'h0000;                       // HALT everywhere
        end
        wp = 10'd0;
    endtask

    task automatic emit(input logic [15:0] ins);
        imem[wp] = ins;
        wp = wp + 10'd1;
    endtask

    // LBI gives the sign extended high byte, SLBI shifts it up and adds the low byte
    task automatic loadReg(input logic [2:0] r, input logic [15:0] val);
        emit(byteInstr(LBI, r, val[15:8]));
        emit(byteInstr(SLBI, r, val[7:0]));
    endtask

    task automatic writeReg(input logic [2:0] r, input logic [15:0] val);
        expValid = 1'b1;
        expAddr  = r;
        expData  = val;
    endtask

    task automatic resetDut();
        @(negedge clk);
        rstN = 1'b0;
        repeat (16) @(negedge clk);
        rstN    = 1'b1;
        mPc     = 16'd0;
        mHalted = 1'b0;
        for (int i = 0; i < 8; i++) begin
            mReg[3'(i)] = 16'd0;
        end
    endtask

    task automatic predict();
        opcodeT      op;
        logic [15:0] ins;
        logic [15:0] rs;
        logic [15:0] rt;
        logic [15:0] s5;
        logic [15:0] s8;
        logic [15:0] ea;
        logic [15:0] res;
        logic [16:0] wide;
        ins  = imem[mPc[10:1]];
        op   = opcodeT'(ins[15:11]);
        rs   = mReg[ins[10:8]];
        rt   = mReg[ins[7:5]];
        s5   = {{11{ins[4]}}, ins[4:0]};
        s8   = {{8{ins[7]}}, ins[7:0]};
        ea   = rs + s5;                                   // Load and store address
        wide = {1'b0, rs} + {1'b0, rt};
        res  = {<<{rs}};
        expValid = 1'b0;
        expAddr  = 3'd0;
        expData  = 16'd0;
        expMemEn = 1'b0;
        expMemWr = 1'b0;
        expMemAddr = ea;
        expMemData = rt;                                  // Store data is the reg at bits 7:5
        expHalt  = 1'b0;
        nextPc   = mPc + 16'd2;
        case (op)
            HALT: begin
                expHalt = 1'b1;
                nextPc  = mPc;
            end
            ADDI:  writeReg(ins[7:5], rs + s5);
            SUBI:  writeReg(ins[7:5], s5 - rs);           // Immediate minus Rs
            XORI:  writeReg(ins[7:5], rs ^ {11'd0, ins[4:0]});
            ANDNI: writeReg(ins[7:5], rs & ~{11'd0, ins[4:0]});
            ROLI:  writeReg(ins[7:5], rotl(rs, ins[3:0]));
            SLLI:  writeReg(ins[7:5], rs << ins[3:0]);
            RORI:  writeReg(ins[7:5], rotr(rs, ins[3:0]));
            SRLI:  writeReg(ins[7:5], rs >> ins[3:0]);
            ST: begin
                expMemEn = 1'b1;
                expMemWr = 1'b1;
            end
            LD: begin
                expMemEn = 1'b1;
                writeReg(ins[7:5], mMem[ea[15:1]]);
            end
            STU: begin
                expMemEn = 1'b1;
                expMemWr = 1'b1;
                writeReg(ins[10:8], ea);
            end
            LBI:   writeReg(ins[10:8], s8);
            SLBI:  writeReg(ins[10:8], {rs[7:0], ins[7:0]});
            BTR:   writeReg(ins[4:2], res);
            ALU_ARITH: begin
                case (ins[1:0])
                    2'b00:   writeReg(ins[4:2], rs + rt);
                    2'b01:   writeReg(ins[4:2], rt - rs);
                    2'b10:   writeReg(ins[4:2], rs ^ rt);
                    default: writeReg(ins[4:2], rs & ~rt);
                endcase
            end
            ALU_SHIFT: begin
                case (ins[1:0])
                    2'b00:   writeReg(ins[4:2], rotl(rs, rt[3:0]));
                    2'b01:   writeReg(ins[4:2], rs << rt[3:0]);
                    2'b10:   writeReg(ins[4:2], rotr(rs, rt[3:0]));
                    default: writeReg(ins[4:2], rs >> rt[3:0]);
                endcase
            end
            SEQ:   writeReg(ins[4:2], {15'd0, rs == rt});
            SLT:   writeReg(ins[4:2], {15'd0, $signed(rs) < $signed(rt)});
            SLE:   writeReg(ins[4:2], {15'd0, $signed(rs) <= $signed(rt)});
            SCO:   writeReg(ins[4:2], {15'd0, wide[16]});
            BEQZ:  if (rs == 16'd0) nextPc = mPc + 16'd2 + s8;
            BNEZ:  if (rs != 16'd0) nextPc = mPc + 16'd2 + s8;
            BLTZ:  if (rs[15]) nextPc = mPc + 16'd2 + s8;
            BGEZ:  if (!rs[15]) nextPc = mPc + 16'd2 + s8;
            J:     nextPc = mPc + 16'd2 + {{5{ins[10]}}, ins[10:0]};
            JAL:   begin
                nextPc = mPc + 16'd2 + {{5{ins[10]}}, ins[10:0]};
                writeReg(3'd7, mPc + 16'd2);              // Return address
            end
            JR:    nextPc = rs + s8;
            JALR: begin
                nextPc = rs + s8;
                writeReg(3'd7, mPc + 16'd2);
            end
            default: ;                                    // NOP, SIIC, RTI
        endcase
        if (mHalted) begin
            expValid = 1'b0;
            expMemEn = 1'b0;
            nextPc   = mPc;                               // Parked until reset
        end
    endtask

    // Runs at the falling edge, where all DUT outputs have settled
    task automatic checkCycle();
        predict();
        checks++;
        if (pc !== mPc) begin
            errors++;
            $display("ERR %0t: pc %h, expected %h", $time, pc, mPc);
        end
        if (halted !== mHalted) begin
            errors++;
            $display("ERR %0t: halted %b, expected %b", $time, halted, mHalted);
        end
        if (wb.valid !== expValid ||
            (expValid && (wb.addr !== expAddr || wb.data !== expData))) begin
            errors++;
            $display("ERR %0t: pc %h wb %b R%0d=%h, expected %b R%0d=%h", $time, mPc,
                     wb.valid, wb.addr, wb.data, expValid, expAddr, expData);
        end
        if (memReq.enable !== expMemEn || (expMemEn && (memReq.write !== expMemWr ||
            memReq.addr !== expMemAddr || (expMemWr && memReq.wrData !== expMemData)))) begin
            errors++;
            $display("ERR %0t: pc %h mem en %b wr %b %h<=%h, expected en %b wr %b %h<=%h",
                     $time, mPc, memReq.enable, memReq.write, memReq.addr, memReq.wrData,
                     expMemEn, expMemWr, expMemAddr, expMemData);
        end
        if (expValid) mReg[expAddr] = expData;
        if (expMemEn && expMemWr) mMem[expMemAddr[15:1]] = expMemData;
        mPc     = nextPc;
        mHalted = mHalted | expHalt;
    endtask

    // HALT closes each program and the core must then stay frozen for ten cycles
    task automatic runProgram();
        int idle;
        emit({HALT, 11'd0});
        $display("Running %s", testName);
        resetDut();
        idle = 0;
        while (idle < 10) begin
            checkCycle();
            if (mHalted) idle++;
            // Halted is visible now, so the parked word becomes live work that must stay blocked
            if (idle >= 2) begin
                imem[mPc[10:1]] = idle[0] ? immInstr(STU, 3'd2, 3'd1, 5'd2)
                                          : jumpInstr(JAL, 11'd6);
            end
            @(negedge clk);
        end
        if (halted !== 1'b1) begin
            errors++;
            $display("ERR %0t: %s ended with halted low", $time, testName);
        end
    endtask

    task automatic rFormatOps();
        logic [15:0] a;
        startProgram("R-format ALU");
        for (int k = 0; k < 4; k++) begin
            a = 16'($random(seed));
            loadReg(3'd1, a);
            loadReg(3'd2, (k == 0) ? a : 16'($random(seed)));  // Equal operands once
            for (int f = 0; f < 4; f++) begin
                emit(rInstr(ALU_ARITH, 3'd1, 3'd2, 3'(3 + f), 2'(f)));
                emit(rInstr(ALU_SHIFT, 3'd2, 3'd1, 3'(4 + f), 2'(f)));
            end
            emit(rInstr(SEQ, 3'd1, 3'd2, 3'd3, 2'd0));
            emit(rInstr(SLT, 3'd1, 3'd2, 3'd4, 2'd0));
            emit(rInstr(SLT, 3'd2, 3'd1, 3'd5, 2'd0));
            emit(rInstr(SLE, 3'd1, 3'd2, 3'd6, 2'd0));
            emit(rInstr(SCO, 3'd1, 3'd2, 3'd7, 2'd0));
            emit(rInstr(BTR, 3'd1, 3'd0, 3'd0, 2'd0));
        end
        runProgram();
    endtask

    task automatic iFormatOps();
        opcodeT     iOps [8];
        logic [4:0] imm;
        iOps = '{ADDI, SUBI, XORI, ANDNI, ROLI, SLLI, RORI, SRLI};
        startProgram("I-format immediates");
        for (int k = 0; k < 4; k++) begin
            loadReg(3'd1, 16'($random(seed)));
            for (int j = 0; j < 8; j++) begin
                imm = 5'($random(seed));
                if (k[0]) imm[4] = 1'b1;                 // Negative 5-bit immediate
                emit(immInstr(iOps[j], 3'd1, 3'(2 + (j % 6)), imm));
            end
        end
        runProgram();
    endtask

    task automatic memoryOps();
        startProgram("load and store");
        loadReg(3'd1, 16'($random(seed)));
        loadReg(3'd2, 16'h0400);                          // Base address
        emit(immInstr(ST, 3'd2, 3'd1, 5'd4));
        emit(immInstr(LD, 3'd2, 3'd3, 5'd4));
        emit(immInstr(LD, 3'd2, 3'd4, 5'h1e));            // Base minus 2 reads the fill pattern
        emit(immInstr(STU, 3'd2, 3'd3, 5'h1c));           // R2 becomes base minus 4
        emit(immInstr(LD, 3'd2, 3'd5, 5'd0));
        emit(immInstr(LD, 3'd2, 3'd6, 5'd8));             // First store via new base
        runProgram();
    endtask

    task automatic branchOps();
        opcodeT     brOp [9];
        logic [2:0] brReg [9];
        brOp  = '{BEQZ, BEQZ, BNEZ, BNEZ, BLTZ, BLTZ, BGEZ, BGEZ, BGEZ};
        brReg = '{3'd1, 3'd2, 3'd2, 3'd1, 3'd3, 3'd2, 3'd2, 3'd3, 3'd1};
        startProgram("branches");
        emit(byteInstr(LBI, 3'd1, 8'd0));
        emit(byteInstr(LBI, 3'd2, 8'd5));
        emit(byteInstr(LBI, 3'd3, 8'hfd));
        for (int i = 0; i < 9; i++) begin
            emit(byteInstr(brOp[i], brReg[i], 8'd2));    // Taken skips the marker
            emit(immInstr(ADDI, 3'd4, 3'd4, 5'd1));
        end
        emit(byteInstr(LBI, 3'd5, 8'd3));
        emit(immInstr(ADDI, 3'd5, 3'd5, 5'h1f));         // Countdown loop body
        emit(byteInstr(BNEZ, 3'd5, 8'hfc));              // Back to the ADDI
        runProgram();
    endtask

    task automatic jumpOps();
        logic [9:0] k;
        startProgram("jumps");
        emit(jumpInstr(J, 11'd2));
        emit(immInstr(ADDI, 3'd6, 3'd6, 5'd1));
        emit(jumpInstr(JAL, 11'd4));
        emit(immInstr(ADDI, 3'd6, 3'd6, 5'd1));
        emit(immInstr(ADDI, 3'd6, 3'd6, 5'd1));
        k = wp;                                           // JR target is slot k+4
        loadReg(3'd1, {5'd0, k + 10'd4, 1'b0});
        emit(byteInstr(JR, 3'd1, 8'd0));
        emit(immInstr(ADDI, 3'd6, 3'd6, 5'd1));
        k = wp;
        loadReg(3'd2, {5'd0, k + 10'd4, 1'b0} + 16'd6);
        emit(byteInstr(JALR, 3'd2, 8'hfa));              // Rs minus 6 lands on slot k+4
        emit(immInstr(ADDI, 3'd6, 3'd6, 5'd1));
        emit(rInstr(ALU_ARITH, 3'd7, 3'd7, 3'd5, 2'd0));
        runProgram();
    endtask

    task automatic haltAndNops();
        startProgram("NOP class and halt");
        loadReg(3'd1, 16'($random(seed)));
        emit({NOP, 11'($random(seed))});
        emit({SIIC, 11'($random(seed))});
        emit({RTI, 11'($random(seed))});
        emit(immInstr(ADDI, 3'd1, 3'd2, 5'd0));
        emit(immInstr(ST, 3'd0, 3'd1, 5'd6));
        runProgram();
    endtask

    initial begin
        seed = 32'h21e3_498d;
        rstN = 1'b0;
        for (int i = 0; i < 32768; i++) begin
            mMem[15'(i)] = {i[14:0], 1'b1} ^ 16'h3c5a;
        end
        rFormatOps();
        iFormatOps();
        memoryOps();
        branchOps();
        jumpOps();
        haltAndNops();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== wiscCore.f ====
+incdir+include
hdl/wiscPkg.sv
hdl/control.sv
hdl/regFile.sv
hdl/decodeStage.sv
hdl/alu.sv
hdl/fetchUnit.sv
hdl/wiscCore.sv
test/wiscCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the core and its testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ns -f wiscCore.f \
    --top-module wiscCoreTb -o wiscCoreSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/wiscCoreSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Test passed" "$LOG"; then
    echo "No pass message found in $LOG"
    exit 1
fi
exit 0
